/* hw/wiscPkg.sv */
package wiscPkg;

   // Datapath and instruction word
   typedef logic [15:0] wordT;
   // One of eight registers
   typedef logic [2:0] regSelT;
   // Instruction bits 15 to 11
   typedef logic [4:0] opcodeT;
   // ALU operation code as the execute stage expects it
   typedef logic [2:0] aluOperT;
   // Top bit marks a branch
   // Low two bits carry the condition
   typedef logic [2:0] brTypeT;

   // Destination register select
   typedef enum logic [1:0] {
      dstRdI  = 2'd0,
      dstRs   = 2'd1,
      dstRdR  = 2'd2,
      dstLink = 2'd3
   } regDstE;

   // Writeback source select
   typedef enum logic [1:0] {
      srcPc  = 2'd0,
      srcMem = 2'd1,
      srcAlu = 2'd2,
      srcB   = 2'd3
   } regSrcE;

   // ALU B input select
   typedef enum logic [1:0] {
      bRt   = 2'd0,
      bImm5 = 2'd1,
      bImm8 = 2'd2,
      bSlbi = 2'd3
   } bSrcE;

   ////////////////////////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////////////////////////
   localparam opcodeT opHalt  = 5'b00000;
   localparam opcodeT opNop   = 5'b00001;
   localparam opcodeT opSiic  = 5'b00010;
   localparam opcodeT opRti   = 5'b00011;
   localparam opcodeT opJ     = 5'b00100;
   localparam opcodeT opJr    = 5'b00101;
   localparam opcodeT opJal   = 5'b00110;
   localparam opcodeT opJalr  = 5'b00111;
   localparam opcodeT opAddi  = 5'b01000;
   localparam opcodeT opSubi  = 5'b01001;
   localparam opcodeT opXori  = 5'b01010;
   localparam opcodeT opAndni = 5'b01011;
   localparam opcodeT opBeqz  = 5'b01100;
   localparam opcodeT opBnez  = 5'b01101;
   localparam opcodeT opBltz  = 5'b01110;
   localparam opcodeT opBgez  = 5'b01111;
   localparam opcodeT opSt    = 5'b10000;
   localparam opcodeT opLd    = 5'b10001;
   localparam opcodeT opSlbi  = 5'b10010;
   localparam opcodeT opStu   = 5'b10011;
   localparam opcodeT opRoli  = 5'b10100;
   localparam opcodeT opSlli  = 5'b10101;
   localparam opcodeT opRori  = 5'b10110;
   localparam opcodeT opSrli  = 5'b10111;
   localparam opcodeT opLbi   = 5'b11000;
   localparam opcodeT opBtr   = 5'b11001;
   // R-format shifts and rotates, function in bits 1 to 0
   localparam opcodeT opShift = 5'b11010;
   // R-format add, sub, xor and andn, function in bits 1 to 0
   localparam opcodeT opArith = 5'b11011;
   localparam opcodeT opSeq   = 5'b11100;
   localparam opcodeT opSlt   = 5'b11101;
   localparam opcodeT opSle   = 5'b11110;
   localparam opcodeT opSco   = 5'b11111;

endpackage

/* hw/decodeCtrlIf.sv */
`timescale 1ns/10ps
`default_nettype none

// Control fields produced by the decoder
interface decodeCtrlIf import wiscPkg::*; ();

   // Program counter controls
   logic    immSrc;
   logic    aluJump;
   brTypeT  brType;

   // ALU controls
   logic    invA;
   logic    invB;
   logic    cin;
   logic    sign;
   bSrcE    bSrc;
   aluOperT oper;

   // Memory control
   logic    memWrt;

   // Register file and writeback controls
   logic    regWrt;
   regDstE  regDst;
   regSrcE  regSrc;

   // Immediate extension mode
   logic    zeroExt;

   modport decoder (
      output immSrc, aluJump, brType,
      output invA, invB, cin, sign, bSrc, oper,
      output memWrt, regWrt, regDst, regSrc, zeroExt
   );

   // Extender only needs the extension mode
   modport ext (input zeroExt);

   // Register file only needs the write enable
   modport rf (input regWrt);

endinterface

`default_nettype wire

/* hw/controlDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module controlDecoder import wiscPkg::*; (
   input  wordT                instruction,
   decodeCtrlIf.decoder        ctrl
);

   // Function codes of the arithmetic R-format opcode
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnAndn = 2'b11;

   opcodeT     opcode;
   logic [1:0] funct;
   logic [2:0] aluSel;

   // Instruction classes
   logic isIdle;
   logic isExcept;
   logic isBranch;
   logic isImmAlu;
   logic isShiftImm;
   logic isMem;
   logic isRFormat;
   logic isCompare;

   assign opcode = instruction[15:11];
   assign funct  = instruction[1:0];

   ////////////////////////////////////////////////////////////
   // Opcode classes
   ////////////////////////////////////////////////////////////
   // HALT and NOP do nothing past decode
   assign isIdle     = opcode inside {opHalt, opNop};
   assign isExcept   = opcode inside {opSiic, opRti};
   assign isBranch   = opcode inside {opBeqz, opBnez, opBltz, opBgez};
   // Five-bit immediate ALU forms
   assign isImmAlu   = opcode inside {opAddi, opSubi, opXori, opAndni};
   assign isShiftImm = opcode inside {opRoli, opSlli, opRori, opSrli};
   // SLBI shares the 100xx space but is not a memory access
   assign isMem      = opcode inside {opSt, opLd, opStu};
   assign isRFormat  = opcode inside {opShift, opArith};
   assign isCompare  = opcode inside {opSeq, opSlt, opSle, opSco};

   // Raw ALU selector before folding
   always_comb begin
      if (isRFormat) begin
         // Shifts land on 0xx and arithmetic on 1xx
         aluSel = {opcode[0], funct};
      end else if (isShiftImm) begin
         aluSel = {1'b0, opcode[1:0]};
      end else if (isImmAlu) begin
         aluSel = {1'b1, opcode[1:0]};
      end else begin
         // Address math, compares and BTR all add
         aluSel = 3'b100;
      end
   end

   ////////////////////////////////////////////////////////////
   // Control fields
   ////////////////////////////////////////////////////////////
   always_comb begin
      // PC source picks the 11-bit offset for J and JAL
      ctrl.immSrc  = opcode inside {opJ, opJal};
      // Register-indirect jumps take the ALU result
      ctrl.aluJump = opcode inside {opJr, opJalr};
      ctrl.memWrt  = opcode inside {opSt, opStu};

      // No writeback for flow control, idle, exceptions and plain stores
      ctrl.regWrt = !(isBranch || isIdle || isExcept ||
                      (opcode inside {opJ, opJr, opSt}));

      // Destination register
      if (opcode inside {opJal, opJalr}) begin
         ctrl.regDst = dstLink;
      end else if (isRFormat || isCompare || opcode == opBtr) begin
         ctrl.regDst = dstRdR;
      end else if (isImmAlu || isShiftImm || isMem ||
                   (opcode inside {opLbi, opSlbi})) begin
         ctrl.regDst = dstRs;
      end else begin
         ctrl.regDst = dstRdI;
      end

      // Writeback source
      if (opcode inside {opLbi, opSlbi}) begin
         ctrl.regSrc = srcB;
      end else if (opcode == opLd) begin
         ctrl.regSrc = srcMem;
      end else if (isIdle || (opcode inside {opJal, opJalr})) begin
         ctrl.regSrc = srcPc;
      end else begin
         ctrl.regSrc = srcAlu;
      end

      // Fold sub onto add and andn onto and
      // Xor moves to the top code
      case (aluSel)
         3'b101:  ctrl.oper = 3'b100;
         3'b110:  ctrl.oper = 3'b111;
         3'b111:  ctrl.oper = 3'b101;
         default: ctrl.oper = aluSel;
      endcase
      if (isIdle) begin
         ctrl.oper = '0;
      end

      // Subtraction negates A
      ctrl.invA = (opcode == opArith && funct == fnSub) || opcode == opSubi;
      // ANDN forms and the Rs minus Rt compares negate B
      ctrl.invB = (opcode == opArith && funct == fnAndn) || opcode == opAndni ||
                  (opcode inside {opSeq, opSlt, opSle});
      // Two's complement needs the extra one
      ctrl.cin  = ctrl.invA || ctrl.invB;

      // B input
      if (isRFormat || isCompare || isIdle) begin
         ctrl.bSrc = bRt;
      end else if (isImmAlu || isShiftImm || isMem) begin
         ctrl.bSrc = bImm5;
      end else if (opcode == opSlbi) begin
         ctrl.bSrc = bSlbi;
      end else begin
         ctrl.bSrc = bImm8;
      end

      // Branch condition rides in the low opcode bits
      ctrl.brType  = isBranch ? {1'b1, opcode[1:0]} : '0;
      // Signed overflow matters everywhere but SCO and idle
      ctrl.sign    = !(opcode == opSco || isIdle);
      ctrl.zeroExt = opcode inside {opXori, opAndni};
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////
   // Sampled on each new word so the previous word's settled decode is seen
   // STU writes back its updated base register
   branchStoreNoWrite: assert property (@(instruction)
      (ctrl.brType[2] || (ctrl.memWrt && opcode != opStu)) |-> !ctrl.regWrt)
      else $error("Branch or store decoded with register write");

endmodule

`default_nettype wire

/* hw/immExtender.sv */
`timescale 1ns/10ps
`default_nettype none

module immExtender import wiscPkg::*; (
   input  wordT         instruction,
   input  logic [7:0]   r2Low,
   decodeCtrlIf.ext     ctrl,
   output wordT         fiveExt,
   output wordT         eightExt,
   output wordT         elevenExt,
   output wordT         slbi
);

   // Fill bits for the short fields
   logic fill5;
   logic fill8;

   // XORI and ANDNI want logical immediates
   // everything else extends the sign bit
   assign fill5 = instruction[4] & ~ctrl.zeroExt;
   assign fill8 = instruction[7] & ~ctrl.zeroExt;

   ////////////////////////////////////////////////////////////
   // Extended immediates
   ////////////////////////////////////////////////////////////
   // I-format 1 field
   assign fiveExt   = {{11{fill5}}, instruction[4:0]};

   // I-format 2 field, also branch and JR offsets
   assign eightExt  = {{8{fill8}}, instruction[7:0]};

   // Jump displacement is always signed
   assign elevenExt = {{5{instruction[10]}}, instruction[10:0]};

   ////////////////////////////////////////////////////////////
   // SLBI operand
   ////////////////////////////////////////////////////////////
   // Old low byte moves up, immediate fills the bottom
   assign slbi = {r2Low, instruction[7:0]};

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import wiscPkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  regSelT       read1Sel,
   input  regSelT       read2Sel,
   input  regSelT       writeSel,
   input  wordT         writeData,
   decodeCtrlIf.rf      ctrl,
   output wordT         read1Data,
   output wordT         read2Data
);

   // One entry per select value
   localparam int numRegs = 2 ** $bits(regSelT);

   wordT regs [0:numRegs-1];

   ////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         // Clear the whole file
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.regWrt) begin
         regs[writeSel] <= writeData;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////////////////////////
   // Asynchronous, no same-cycle bypass
   assign read1Data = regs[read1Sel];
   assign read2Data = regs[read2Sel];

   // Written value must be there one edge later
   writeLands: assert property (@(posedge clk) disable iff (reset)
      ctrl.regWrt |=> (regs[$past(writeSel)] == $past(writeData)))
      else $error("Register write did not land");

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/10ps
`default_nettype none

module decode import wiscPkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  wordT      instruction,
   input  regSelT    writeReg,
   input  wordT      writeData,
   // PC controls
   output logic      immSrc,
   output logic      aluJump,
   output brTypeT    brType,
   // Memory control
   output logic      memWrt,
   // ALU controls
   output logic      invA,
   output logic      invB,
   output logic      cin,
   output logic      sign,
   output bSrcE      bSrc,
   output aluOperT   oper,
   // Writeback controls
   output regDstE    regDst,
   output regSrcE    regSrc,
   // Extended immediates
   output wordT      fiveExt,
   output wordT      eightExt,
   output wordT      elevenExt,
   // Register reads
   output wordT      r1,
   output wordT      r2,
   // For execute
   output opcodeT    opcode,
   output wordT      slbi
);

   decodeCtrlIf ctrlBus ();

   assign opcode = instruction[15:11];

   ////////////////////////////////////////////////////////////
   // Submodules
   ////////////////////////////////////////////////////////////
   controlDecoder uDecoder (
      .instruction (instruction),
      .ctrl        (ctrlBus.decoder)
   );

   // Rt low byte feeds the SLBI value
   immExtender uExtender (
      .instruction (instruction),
      .r2Low       (r2[7:0]),
      .ctrl        (ctrlBus.ext),
      .fiveExt     (fiveExt),
      .eightExt    (eightExt),
      .elevenExt   (elevenExt),
      .slbi        (slbi)
   );

   // Rs on port 1, Rt on port 2
   regFile uRegFile (
      .clk       (clk),
      .reset     (reset),
      .read1Sel  (instruction[10:8]),
      .read2Sel  (instruction[7:5]),
      .writeSel  (writeReg),
      .writeData (writeData),
      .ctrl      (ctrlBus.rf),
      .read1Data (r1),
      .read2Data (r2)
   );

   // Remaining control fields go straight out
   assign immSrc  = ctrlBus.immSrc;
   assign aluJump = ctrlBus.aluJump;
   assign brType  = ctrlBus.brType;
   assign memWrt  = ctrlBus.memWrt;
   assign invA    = ctrlBus.invA;
   assign invB    = ctrlBus.invB;
   assign cin     = ctrlBus.cin;
   assign sign    = ctrlBus.sign;
   assign bSrc    = ctrlBus.bSrc;
   assign oper    = ctrlBus.oper;
   assign regDst  = ctrlBus.regDst;
   assign regSrc  = ctrlBus.regSrc;

endmodule

`default_nettype wire

/* testbench/decodeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeTb import wiscPkg::*; ();

   ////////////////////////////////////////////////////////////
   // Run parameters
   ////////////////////////////////////////////////////////////
   localparam int numVectors  = 30;
   // Words per trace line
   localparam int vecWords    = 10;
   localparam int clkPeriod   = 8;
   localparam int resetCycles = 5;
   // Trace plus reset plus slack
   localparam int cycleLimit  = numVectors + resetCycles + 20;

   // Word positions within one trace line
   localparam int colInstr   = 0;
   localparam int colWrReg   = 1;
   localparam int colWrData  = 2;
   localparam int colR1      = 3;
   localparam int colR2      = 4;
   localparam int colSlbi    = 5;
   localparam int colFive    = 6;
   localparam int colEight   = 7;
   localparam int colEleven  = 8;
   localparam int colCtrl    = 9;

   // DUT inputs
   logic    clk;
   logic    reset;
   wordT    instruction;
   regSelT  writeReg;
   wordT    writeData;

   // DUT outputs
   logic    immSrc;
   logic    aluJump;
   brTypeT  brType;
   logic    memWrt;
   logic    invA;
   logic    invB;
   logic    cin;
   logic    sign;
   bSrcE    bSrc;
   aluOperT oper;
   regDstE  regDst;
   regSrcE  regSrc;
   wordT    fiveExt;
   wordT    eightExt;
   wordT    elevenExt;
   wordT    r1;
   wordT    r2;
   opcodeT  opcode;
   wordT    slbi;

   // Whole trace, one word per column
   logic [31:0] traceMem [0:numVectors*vecWords-1];
   int          cycleCount = 0;

   decode u_dut (
      .clk         (clk),
      .reset       (reset),
      .instruction (instruction),
      .writeReg    (writeReg),
      .writeData   (writeData),
      .immSrc      (immSrc),
      .aluJump     (aluJump),
      .brType      (brType),
      .memWrt      (memWrt),
      .invA        (invA),
      .invB        (invB),
      .cin         (cin),
      .sign        (sign),
      .bSrc        (bSrc),
      .oper        (oper),
      .regDst      (regDst),
      .regSrc      (regSrc),
      .fiveExt     (fiveExt),
      .eightExt    (eightExt),
      .elevenExt   (elevenExt),
      .r1          (r1),
      .r2          (r2),
      .opcode      (opcode),
      .slbi        (slbi)
   );

   ////////////////////////////////////////////////////////////
   // Clock and timeout
   ////////////////////////////////////////////////////////////
   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Ends a run that stalls past the expected length
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Run did not finish within %0d cycles", cycleLimit);
         $display("Errors found");
         $fatal(1, "Timeout");
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   // Compare one field, stop at the first mismatch
   task automatic compareField(input int index, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[FAIL] vector %0d %s: expected %h, actual %h",
                  index, field, expected, actual);
         $display("Errors found");
         $fatal(1, "Output mismatch");
      end
   endtask

   // Control outputs in the trace layout, one field per hex digit
   function automatic logic [31:0] packedControls();
      return {5'd0, oper, 2'd0, regSrc, 2'd0, regDst, 2'd0, bSrc,
              1'b0, brType, sign, cin, invB, invA,
              1'b0, memWrt, aluJump, immSrc};
   endfunction

   // Apply instruction and writeback port of one vector
   task automatic driveVector(input int index);
      int base;
      base = index * vecWords;
      instruction <= traceMem[base + colInstr][15:0];
      writeReg    <= traceMem[base + colWrReg][2:0];
      writeData   <= traceMem[base + colWrData][15:0];
   endtask

   // Every output against the trace
   task automatic verifyVector(input int index);
      int          base;
      logic [31:0] expOpcode;
      base = index * vecWords;
      // Opcode is the top five instruction bits
      expOpcode = {27'd0, traceMem[base + colInstr][15:11]};
      compareField(index, "opcode", expOpcode, 32'(opcode));
      compareField(index, "r1", traceMem[base + colR1], 32'(r1));
      compareField(index, "r2", traceMem[base + colR2], 32'(r2));
      compareField(index, "slbi", traceMem[base + colSlbi], 32'(slbi));
      compareField(index, "fiveExt", traceMem[base + colFive], 32'(fiveExt));
      compareField(index, "eightExt", traceMem[base + colEight], 32'(eightExt));
      compareField(index, "elevenExt", traceMem[base + colEleven], 32'(elevenExt));
      compareField(index, "controls", traceMem[base + colCtrl], packedControls());
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////
   initial begin
      reset       = 1'b1;
      instruction = '0;
      writeReg    = '0;
      writeData   = '0;
      $readmemh("testbench/decodeTrace.hex", traceMem);

      // Register file clears while reset is high
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;

      // New vector on the rising edge, check at mid-cycle
      for (int v = 0; v < numVectors; v++) begin
         @(posedge clk);
         driveVector(v);
         @(negedge clk);
         verifyVector(v);
      end

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/decodeTrace.hex */
// instr wrReg wrData r1 r2 slbi fiveExt eightExt elevenExt ctrl
// ctrl digits from high: 0 oper regSrc regDst bSrc brType {sign cin invB invA} {0 memWrt aluJump immSrc}
0820 1 DEAD 0000 0000 0020 0000 0020 0020 00000000
0A60 3 BEEF 0000 0000 0060 0000 0060 0260 00000000
0CA0 5 1234 0000 0000 00A0 0000 FFA0 FCA0 00000000
06E0 7 5555 0000 0000 00E0 0000 FFE0 FEE0 00000000
4153 1 1111 0000 0000 0053 FFF3 0053 0153 04211080
4965 2 2222 1111 0000 0065 0005 0065 0165 042110D0
52BC 3 3333 2222 0000 00BC 001C 00BC 02BC 07211080
5B9F 4 4444 3333 0000 009F 001F 009F 039F 052110E0
439F 5 5A5A 3333 4444 449F FFFF FF9F 039F 04211080
DCB9 6 6666 4444 5A5A 5AB9 FFF9 FFB9 FCB9 042200D0
DE3F 7 7777 6666 1111 113F FFFF 003F FE3F 052200E0
DFC0 0 0F0F 7777 6666 66C0 0000 FFC0 FFC0 04220080
E044 1 1AB1 0F0F 2222 2244 0004 0044 0044 042200E0
F968 2 2BC2 1AB1 3333 3368 0008 0068 0168 04220000
6280 4 BAD0 2BC2 4444 4480 0000 FF80 0280 04202480
7C7F 3 BAD1 4444 3333 337F FFFF 007F FC7F 04202780
2400 4 BAD2 4444 0F0F 0F00 0000 0000 FC00 04202081
2B04 3 BAD3 3333 0F0F 0F04 0004 0004 0304 04202082
37FF 7 0102 7777 7777 77FF FFFF FFFF FFFF 04032081
3F10 6 6006 0102 0F0F 0F10 FFF0 0010 FF10 04032082
8EA2 5 5005 6006 5A5A 5AA2 0002 FFA2 FEA2 04111080
8511 0 BAD4 5005 0F0F 0F11 FFF1 0011 FD11 04211084
C2C3 2 FFC3 2BC2 6006 06C3 0003 FFC3 02C3 04312080
913C 1 B13C 1AB1 1AB1 B13C FFFC 003C 013C 04313080
93E5 3 02E5 3333 0102 02E5 0005 FFE5 03E5 04313080
CB10 4 A74C 02E5 0F0F 0F10 FFF0 0010 0310 04222080
0C60 0 BAD5 A74C 02E5 E560 0000 0060 FC60 00000000
0220 1 BAD6 FFC3 B13C 3C20 0000 0020 0220 00000000
A8C3 6 0000 0F0F 6006 06C3 0003 FFC3 00C3 01211080
0EE0 5 BAD7 0000 0102 02E0 0000 FFE0 FEE0 00000000

/* decode.f */
hw/wiscPkg.sv
hw/decodeCtrlIf.sv
hw/controlDecoder.sv
hw/immExtender.sv
hw/regFile.sv
hw/decode.sv
testbench/decodeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decodeTb
FLIST     ?= decode.f
TRACE     ?= testbench/decodeTrace.hex
OBJDIR    ?= obj_dir
VFLAGS    ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it against $(TRACE)"
	@echo "  clean  remove $(OBJDIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST TRACE OBJDIR VFLAGS"

test: $(FLIST) $(TRACE)
	$(VERILATOR) --binary --top-module $(TOP) --Mdir $(OBJDIR) $(VFLAGS) -f $(FLIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf $(OBJDIR)
